/* source/cpu_pkg.sv */
package cpu_pkg;

    // basic widths
    typedef logic [31:0] word_t;      // instruction word and pc
    typedef logic [7:0]  data_t;      // register and memory byte
    typedef logic [2:0]  reg_addr_t;  // register index
    typedef logic [7:0]  opcode_t;    // opcode field
    typedef logic [1:0]  alu_op_t;    // alu function select

    // instruction field start bits
    localparam int OPCODE_LSB = 24;
    localparam int OFFSET_LSB = 16;   // branch and jump offset
    localparam int DEST_LSB   = 16;   // overlaps offset, never used together
    localparam int SRC1_LSB   = 8;
    localparam int SRC2_LSB   = 0;

    // pc moves one word per instruction
    localparam word_t PC_STEP = 32'd4;

    localparam int NUM_REGS = 8;

    // opcodes
    localparam opcode_t OP_LOADI = 8'd0;
    localparam opcode_t OP_MOV   = 8'd1;
    localparam opcode_t OP_ADD   = 8'd2;
    localparam opcode_t OP_SUB   = 8'd3;
    localparam opcode_t OP_AND   = 8'd4;
    localparam opcode_t OP_OR    = 8'd5;
    localparam opcode_t OP_J     = 8'd6;
    localparam opcode_t OP_BEQ   = 8'd7;
    // 8 to 11 are unused
    localparam opcode_t OP_BNE   = 8'd12;
    localparam opcode_t OP_LWD   = 8'd13;  // load, address in register
    localparam opcode_t OP_LWI   = 8'd14;  // load, address in immediate
    localparam opcode_t OP_SWD   = 8'd15;  // store, address in register
    localparam opcode_t OP_SWI   = 8'd16;  // store, address in immediate

    // alu functions
    localparam alu_op_t ALU_FWD = 2'd0;    // pass operand 2
    localparam alu_op_t ALU_ADD = 2'd1;
    localparam alu_op_t ALU_AND = 2'd2;
    localparam alu_op_t ALU_OR  = 2'd3;

endpackage

/* source/instruction_decoder.sv */
`timescale 1ns/100ps

module instruction_decoder
(
    input  logic                 RESET,
    input  cpu_pkg::word_t       instruction,
    output cpu_pkg::reg_addr_t   src1,
    output cpu_pkg::reg_addr_t   src2,
    output cpu_pkg::reg_addr_t   dest,
    output cpu_pkg::data_t       immediate,
    output cpu_pkg::data_t       offset,
    output cpu_pkg::alu_op_t     alu_op,
    output logic                 negate,
    output logic                 use_imm,
    output logic                 reg_write,
    output logic                 mem_to_reg,
    output logic                 branch_eq,
    output logic                 branch_ne,
    output logic                 jump,
    output logic                 mem_read,
    output logic                 mem_write
);
    import cpu_pkg::*;

    opcode_t opcode;
    logic    rd_req;   // decoded load
    logic    wr_req;   // decoded store

    assign opcode    = instruction[OPCODE_LSB +: $bits(opcode_t)];
    assign offset    = instruction[OFFSET_LSB +: $bits(data_t)];
    assign dest      = instruction[DEST_LSB +: $bits(reg_addr_t)];
    assign src1      = instruction[SRC1_LSB +: $bits(reg_addr_t)];
    assign src2      = instruction[SRC2_LSB +: $bits(reg_addr_t)];
    assign immediate = instruction[$bits(data_t)-1:0];

    always_comb
    begin
        alu_op     = ALU_FWD;
        negate     = 1'b0;
        use_imm    = 1'b0;
        reg_write  = 1'b0;
        mem_to_reg = 1'b0;
        branch_eq  = 1'b0;
        branch_ne  = 1'b0;
        jump       = 1'b0;
        rd_req     = 1'b0;
        wr_req     = 1'b0;
        case (opcode)
            OP_LOADI:
            begin
                use_imm   = 1'b1;
                reg_write = 1'b1;
            end
            OP_MOV:    reg_write = 1'b1;   // forward of data2
            OP_ADD:
            begin
                alu_op    = ALU_ADD;
                reg_write = 1'b1;
            end
            OP_SUB:
            begin
                alu_op    = ALU_ADD;
                negate    = 1'b1;          // add of the negated operand
                reg_write = 1'b1;
            end
            OP_AND:
            begin
                alu_op    = ALU_AND;
                reg_write = 1'b1;
            end
            OP_OR:
            begin
                alu_op    = ALU_OR;
                reg_write = 1'b1;
            end
            OP_J:      jump = 1'b1;
            OP_BEQ:
            begin
                alu_op    = ALU_ADD;       // zero flag compares the sources
                negate    = 1'b1;
                branch_eq = 1'b1;
            end
            OP_BNE:
            begin
                alu_op    = ALU_ADD;
                negate    = 1'b1;
                branch_ne = 1'b1;
            end
            OP_LWD:
            begin
                reg_write  = 1'b1;
                mem_to_reg = 1'b1;
                rd_req     = 1'b1;
            end
            OP_LWI:
            begin
                use_imm    = 1'b1;
                reg_write  = 1'b1;
                mem_to_reg = 1'b1;
                rd_req     = 1'b1;
            end
            OP_SWD:    wr_req = 1'b1;      // address from src2, data from src1
            OP_SWI:
            begin
                use_imm = 1'b1;
                wr_req  = 1'b1;
            end
            default:   ;                   // unknown opcode acts as a nop
        endcase
    end

    // no memory traffic while in reset
    assign mem_read  = rd_req & ~RESET;
    assign mem_write = wr_req & ~RESET;

    // checked on every instruction change, against the settled decode
    a_strobe_excl: assert property (@(instruction) !(mem_read && mem_write))
        else $error("mem_read and mem_write high together");

endmodule

/* source/program_counter.sv */
`timescale 1ns/100ps

module program_counter
(
    input  logic            CLK,
    input  logic            RESET,
    input  logic            mem_busywait,
    input  logic            jump,
    input  logic            branch_eq,
    input  logic            branch_ne,
    input  logic            zero,
    input  cpu_pkg::data_t  offset,
    output cpu_pkg::word_t  pc
);
    import cpu_pkg::*;

    word_t pc_plus4;
    word_t offset_ext;   // sign extended, in bytes
    word_t target;
    word_t next_pc;
    logic  taken;

    assign pc_plus4 = pc + PC_STEP;

    // offset counts words, so shift by two
    assign offset_ext = {{($bits(word_t) - $bits(data_t) - 2){offset[$bits(data_t)-1]}},
                         offset, 2'b00};

    assign target = pc_plus4 + offset_ext;   // relative to the next instruction

    assign taken = (branch_eq & zero) | (branch_ne & ~zero);

    assign next_pc = (jump | taken) ? target : pc_plus4;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            pc <= '0;
        end
        else if (!mem_busywait)   // hold until the memory access completes
        begin
            pc <= next_pc;
        end
    end

    a_pc_aligned: assert property (@(posedge CLK) disable iff (RESET)
                                   pc[1:0] == 2'b00)
        else $error("pc not word aligned");

endmodule

/* source/reg_file.sv */
`timescale 1ns/100ps

module reg_file
(
    input  logic                CLK,
    input  logic                RESET,
    input  cpu_pkg::reg_addr_t  src1,
    input  cpu_pkg::reg_addr_t  src2,
    input  cpu_pkg::reg_addr_t  dest,
    input  logic                reg_write,
    input  logic                mem_to_reg,
    input  logic                mem_busywait,
    input  cpu_pkg::data_t      alu_result,
    input  cpu_pkg::data_t      mem_readdata,
    output cpu_pkg::data_t      data1,
    output cpu_pkg::data_t      data2
);
    import cpu_pkg::*;

    data_t [NUM_REGS-1:0] regs;
    data_t                write_data;
    logic                 write_en;

    // loads take the memory byte, everything else the alu result
    assign write_data = mem_to_reg ? mem_readdata : alu_result;

    // a stalled load must not write stale read data
    assign write_en = reg_write & ~mem_busywait;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            regs <= '0;
        end
        else if (write_en)
        begin
            regs[dest] <= write_data;
        end
    end

    assign data1 = regs[src1];   // also the store data
    assign data2 = regs[src2];

    // busywait at an edge means nothing retires there
    a_stall_hold: assert property (@(posedge CLK) disable iff (RESET)
                                   mem_busywait |=> $stable(regs))
        else $error("register written during a memory stall");

endmodule

/* source/alu.sv */
`timescale 1ns/100ps

module alu
(
    input  cpu_pkg::data_t   data1,
    input  cpu_pkg::data_t   data2,
    input  cpu_pkg::data_t   immediate,
    input  cpu_pkg::alu_op_t alu_op,
    input  logic             negate,
    input  logic             use_imm,
    output cpu_pkg::data_t   alu_result,
    output logic             zero
);
    import cpu_pkg::*;

    data_t operand2;
    data_t reg_operand;   // data2 or its two's complement
    data_t sum;

    assign reg_operand = negate ? (~data2 + 8'd1) : data2;

    assign operand2 = use_imm ? immediate : reg_operand;

    assign sum = data1 + operand2;   // wraps at 8 bits

    always_comb
    begin
        case (alu_op)
            ALU_FWD: alu_result = operand2;
            ALU_ADD: alu_result = sum;
            ALU_AND: alu_result = data1 & operand2;
            ALU_OR:  alu_result = data1 | operand2;
            default: alu_result = operand2;
        endcase
    end

    // beq and bne subtract, so this is data1 == data2
    assign zero = (sum == '0);

endmodule

/* source/cpu.sv */
`timescale 1ns/100ps

module cpu
(
    input  logic            CLK,
    input  logic            RESET,
    input  cpu_pkg::word_t  instruction,
    input  cpu_pkg::data_t  mem_readdata,
    input  logic            mem_busywait,
    output cpu_pkg::word_t  pc,
    output logic            mem_read,
    output logic            mem_write,
    output cpu_pkg::data_t  mem_address,
    output cpu_pkg::data_t  mem_writedata
);
    import cpu_pkg::*;

    reg_addr_t src1;
    reg_addr_t src2;
    reg_addr_t dest;
    data_t     immediate;
    data_t     offset;
    alu_op_t   alu_op;
    logic      negate;
    logic      use_imm;
    logic      reg_write;
    logic      mem_to_reg;
    logic      branch_eq;
    logic      branch_ne;
    logic      jump;
    data_t     data1;
    data_t     data2;
    data_t     alu_result;
    logic      zero;

    assign mem_address   = alu_result;   // loads and stores address through the alu
    assign mem_writedata = data1;

    instruction_decoder i_decoder
    (
        .RESET       (RESET),
        .instruction (instruction),
        .src1        (src1),
        .src2        (src2),
        .dest        (dest),
        .immediate   (immediate),
        .offset      (offset),
        .alu_op      (alu_op),
        .negate      (negate),
        .use_imm     (use_imm),
        .reg_write   (reg_write),
        .mem_to_reg  (mem_to_reg),
        .branch_eq   (branch_eq),
        .branch_ne   (branch_ne),
        .jump        (jump),
        .mem_read    (mem_read),
        .mem_write   (mem_write)
    );

    program_counter i_pc
    (
        .CLK          (CLK),
        .RESET        (RESET),
        .mem_busywait (mem_busywait),
        .jump         (jump),
        .branch_eq    (branch_eq),
        .branch_ne    (branch_ne),
        .zero         (zero),
        .offset       (offset),
        .pc           (pc)
    );

    reg_file i_reg_file
    (
        .CLK          (CLK),
        .RESET        (RESET),
        .src1         (src1),
        .src2         (src2),
        .dest         (dest),
        .reg_write    (reg_write),
        .mem_to_reg   (mem_to_reg),
        .mem_busywait (mem_busywait),
        .alu_result   (alu_result),
        .mem_readdata (mem_readdata),
        .data1        (data1),
        .data2        (data2)
    );

    alu i_alu
    (
        .data1      (data1),
        .data2      (data2),
        .immediate  (immediate),
        .alu_op     (alu_op),
        .negate     (negate),
        .use_imm    (use_imm),
        .alu_result (alu_result),
        .zero       (zero)
    );

endmodule

/* dv/cpu_tb.sv */
`timescale 1ns/100ps

module cpu_tb;
    import cpu_pkg::*;

    localparam int    STORE_TIMEOUT = 200;      // cycles allowed per expected store
    localparam int    QUIET_CYCLES  = 40;
    localparam word_t HALT_PC       = 32'd148;  // j -1 at word 37

    logic  CLK;
    logic  RESET;
    word_t instruction;
    data_t mem_readdata;
    logic  mem_busywait;
    word_t pc;
    logic  mem_read;
    logic  mem_write;
    data_t mem_address;
    data_t mem_writedata;

    word_t       imem [64];
    int          prog_len;
    data_t       data_mem [256];
    logic        in_access;      // access already seen at an edge
    int          wait_cnt;       // busy cycles still to go
    int          seed;
    logic [15:0] store_q [$];    // observed {address, data}
    logic [15:0] expect_q [$];
    word_t       prev_pc;
    logic        prev_mem;
    logic        prev_busy;
    logic        have_prev;

    cpu i_cpu
    (
        .CLK           (CLK),
        .RESET         (RESET),
        .instruction   (instruction),
        .mem_readdata  (mem_readdata),
        .mem_busywait  (mem_busywait),
        .pc            (pc),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .mem_address   (mem_address),
        .mem_writedata (mem_writedata)
    );

    initial
    begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    assign instruction  = imem[pc[7:2]];   // word addressed
    assign mem_busywait = (mem_read | mem_write) & ~(in_access & (wait_cnt == 0));

    // data memory, 1 to 4 busy cycles per access
    always @(posedge CLK)
    begin
        if (mem_read || mem_write)
        begin
            if (!in_access)
            begin
                in_access <= 1'b1;
                wait_cnt  <= $random(seed) & 3;
            end
            else if (wait_cnt != 0)
            begin
                wait_cnt <= wait_cnt - 1;
            end
            else
            begin
                in_access <= 1'b0;   // completion edge
                if (mem_write)
                    data_mem[mem_address] <= mem_writedata;
            end
            if (mem_read)
                mem_readdata <= data_mem[mem_address];
        end
    end

    task automatic end_with_failure();
        $display("Done: errors found");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic report_mismatch(input string what);
        $display("[ERROR] %0t: %s", $time, what);
        end_with_failure();
    endtask

    // stall and advance of pc, plus store capture, sampled mid cycle
    always @(negedge CLK)
    begin
        if (RESET)
        begin
            have_prev = 1'b0;
        end
        else
        begin
            if (have_prev && prev_mem && prev_busy)
                assert (pc == prev_pc)
                else report_mismatch($sformatf("pc moved during stall, %h to %h", prev_pc, pc));
            else if (have_prev && prev_mem)
                assert (pc == prev_pc + 32'd4)
                else report_mismatch($sformatf("pc %h after access at %h", pc, prev_pc));
            if (mem_write && !mem_busywait)
                store_q.push_back({mem_address, mem_writedata});
            prev_pc   = pc;
            prev_mem  = mem_read | mem_write;
            prev_busy = mem_busywait;
            have_prev = 1'b1;
        end
    end

    function automatic word_t assemble(input opcode_t op, input data_t hi,
                                       input reg_addr_t s1, input data_t lo);
        assemble = {op, hi, 5'b00000, s1, lo};   // hi is dest or offset
    endfunction

    task automatic emit(input word_t w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    task automatic expect_store(input data_t addr, input data_t data);
        expect_q.push_back({addr, data});
    endtask

    task automatic check_idle(input string where);
        assert (pc == '0 && !mem_read && !mem_write)
        else report_mismatch($sformatf("%s: pc %h read %b write %b",
                                       where, pc, mem_read, mem_write));
    endtask

    task automatic load_program();
        emit(assemble(OP_LOADI, 8'd1, 3'd0, 8'hc8));
        emit(assemble(OP_LOADI, 8'd2, 3'd0, 8'h64));
        emit(assemble(OP_ADD,   8'd3, 3'd1, 8'd2));     // 0x2c after wrap
        emit(assemble(OP_SWI,   8'd0, 3'd3, 8'h10));
        emit(assemble(OP_SUB,   8'd4, 3'd2, 8'd1));     // 100 - 200 = 0x9c
        emit(assemble(OP_SWI,   8'd0, 3'd4, 8'h11));
        emit(assemble(OP_AND,   8'd5, 3'd1, 8'd2));
        emit(assemble(OP_SWI,   8'd0, 3'd5, 8'h12));
        emit(assemble(OP_OR,    8'd6, 3'd1, 8'd2));
        emit(assemble(OP_SWI,   8'd0, 3'd6, 8'h13));
        emit(assemble(OP_MOV,   8'd7, 3'd0, 8'd6));
        emit(assemble(OP_SWI,   8'd0, 3'd7, 8'h14));
        emit(assemble(OP_LOADI, 8'd1, 3'd0, 8'h20));
        emit(assemble(OP_LOADI, 8'd2, 3'd0, 8'ha5));
        emit(assemble(OP_SWD,   8'd0, 3'd2, 8'd1));     // mem[r1] = r2
        emit(assemble(OP_SWI,   8'd0, 3'd1, 8'h21));
        emit(assemble(OP_LWD,   8'd3, 3'd0, 8'd1));
        emit(assemble(OP_LWI,   8'd4, 3'd0, 8'h21));
        emit(assemble(OP_SWI,   8'd0, 3'd3, 8'h30));
        emit(assemble(OP_SWI,   8'd0, 3'd4, 8'h31));
        emit(assemble(OP_BEQ,   8'd1, 3'd3, 8'd2));     // taken
        emit(assemble(OP_SWI,   8'd0, 3'd4, 8'he0));    // skipped marker
        emit(assemble(OP_BEQ,   8'd1, 3'd3, 8'd4));     // not taken
        emit(assemble(OP_SWI,   8'd0, 3'd3, 8'h40));
        emit(assemble(OP_BNE,   8'd1, 3'd3, 8'd4));     // taken
        emit(assemble(OP_SWI,   8'd0, 3'd4, 8'he1));    // skipped marker
        emit(assemble(OP_BNE,   8'd1, 3'd3, 8'd2));     // not taken
        emit(assemble(OP_SWI,   8'd0, 3'd4, 8'h41));
        emit(assemble(OP_J,     8'd1, 3'd0, 8'd0));
        emit(assemble(OP_SWI,   8'd0, 3'd3, 8'he2));    // skipped marker
        emit(assemble(OP_LOADI, 8'd5, 3'd0, 8'd0));
        emit(assemble(OP_LOADI, 8'd6, 3'd0, 8'd1));
        emit(assemble(OP_LOADI, 8'd7, 3'd0, 8'd3));
        emit(assemble(OP_ADD,   8'd5, 3'd5, 8'd6));     // loop top, word 33
        emit(assemble(OP_SWI,   8'd0, 3'd5, 8'h50));
        emit(assemble(OP_BNE,   8'hfd, 3'd5, 8'd7));    // back to word 33
        emit(assemble(OP_SWI,   8'd0, 3'd7, 8'h51));
        while (prog_len < 64)
            emit(assemble(OP_J, 8'hff, 3'd0, 8'd0));    // halt in place
    endtask

    task automatic load_expected();
        expect_store(8'h10, 8'h2c);
        expect_store(8'h11, 8'h9c);
        expect_store(8'h12, 8'h40);
        expect_store(8'h13, 8'hec);
        expect_store(8'h14, 8'hec);
        expect_store(8'h20, 8'ha5);
        expect_store(8'h21, 8'h20);
        expect_store(8'h30, 8'ha5);
        expect_store(8'h31, 8'h20);
        expect_store(8'h40, 8'ha5);
        expect_store(8'h41, 8'h20);
        expect_store(8'h50, 8'h01);
        expect_store(8'h50, 8'h02);
        expect_store(8'h50, 8'h03);
        expect_store(8'h51, 8'h03);
    endtask

    initial
    begin
        int          i;
        int          n;
        int          waited;
        logic [15:0] got;
        logic [15:0] want;
        $timeformat(-9, 1, " ns", 0);
        RESET        = 1'b1;
        seed         = 32'h957608c5;
        in_access    = 1'b0;
        wait_cnt     = 0;
        mem_readdata = '0;
        have_prev    = 1'b0;
        prog_len     = 0;
        for (i = 0; i < 256; i++)
            data_mem[i] = data_t'(i) ^ 8'h5a;
        load_program();
        load_expected();

        repeat (3)
        begin
            @(negedge CLK);
            check_idle("during reset");
        end
        @(posedge CLK);
        RESET <= 1'b0;   // fourth reset cycle ends here
        @(negedge CLK);
        check_idle("first cycle after reset");

        n = 0;
        while (expect_q.size() != 0)
        begin
            want   = expect_q.pop_front();
            waited = 0;
            while (store_q.size() == 0 && waited < STORE_TIMEOUT)
            begin
                @(posedge CLK);
                waited++;
            end
            if (store_q.size() == 0)
            begin
                $display("timeout: store %0d to address %h never came", n, want[15:8]);
                end_with_failure();
            end
            else
            begin
                got = store_q.pop_front();
                assert (got == want)
                else report_mismatch($sformatf("store %0d got %h <- %h, expected %h <- %h",
                                               n, got[15:8], got[7:0], want[15:8], want[7:0]));
                n++;
            end
        end

        repeat (QUIET_CYCLES) @(posedge CLK);   // markers or extra stores would show here
        assert (store_q.size() == 0)
        else report_mismatch($sformatf("%0d unexpected stores", store_q.size()));
        assert (pc == HALT_PC)
        else report_mismatch($sformatf("pc %h, expected halt at %h", pc, HALT_PC));
        $display("Done: no errors");
        $finish;
    end

endmodule

/* tb.f */
source/cpu_pkg.sv
source/instruction_decoder.sv
source/program_counter.sv
source/reg_file.sv
source/alu.sv
source/cpu.sv
dv/cpu_tb.sv

/* Bender.yml */
package:
  name: cpu8

sources:
  - files:
      - source/cpu_pkg.sv
      - source/instruction_decoder.sv
      - source/program_counter.sv
      - source/reg_file.sv
      - source/alu.sv
      - source/cpu.sv
  - target: simulation
    files:
      - dv/cpu_tb.sv
